// ==== files.f ====
rtl/ctrlPkg.sv
rtl/instrDecoder.sv
rtl/stageReg.sv
rtl/forwardUnit.sv
rtl/branchResolve.sv
rtl/pipeCtrl.sv
testbench/pipeCtrlTb.sv

// ==== rtl/branchResolve.sv ====
`timescale 1ns/1ps

module branchResolve (
    input  ctrlPkg::memBundle_t memCtrl,
    input  logic                jumpTaken,   // front end predicted taken
    input  logic          [1:0] flushIn,
    output logic                pcSel,
    output logic                branchResolved,
    output logic                actualTaken,
    output logic                mispredict,
    output logic          [1:0] flushOut
);
    import ctrlPkg::*;

    logic outcome;    // branch condition met

    always_comb begin
        case (memCtrl.funct3)
            F3Beq:          outcome = memCtrl.brEq;
            F3Bne:          outcome = !memCtrl.brEq;
            F3Blt, F3Bltu:  outcome = memCtrl.brLt;   // comparator already signed/unsigned
            F3Bge, F3Bgeu:  outcome = !memCtrl.brLt;
            default:        outcome = 1'b0;
        endcase
    end

    //////////////////////////////
    // redirect decision
    //////////////////////////////
    always_comb begin
        pcSel          = 1'b0;
        branchResolved = 1'b0;
        actualTaken    = 1'b0;
        mispredict     = 1'b0;
        if (memCtrl.isJump) begin
            pcSel = !jumpTaken;     // predicted jumps already fetched the target
        end else if (memCtrl.isBranch) begin
            branchResolved = 1'b1;
            actualTaken    = outcome;
            if (jumpTaken) begin
                // predicted taken, wrong only when not taken
                pcSel      = !outcome;
                mispredict = !outcome;
            end else begin
                pcSel = outcome;
            end
        end
    end

    // redirect kills the two younger stages
    assign flushOut = pcSel ? 2'b11 : flushIn;

endmodule

// ==== rtl/ctrlPkg.sv ====
package ctrlPkg;

    //////////////////////////////
    // opcode field, instr[6:2]
    //////////////////////////////
    localparam logic [4:0] OpLoad   = 5'b00000;
    localparam logic [4:0] OpImm    = 5'b00100;
    localparam logic [4:0] OpAuipc  = 5'b00101;
    localparam logic [4:0] OpStore  = 5'b01000;
    localparam logic [4:0] OpReg    = 5'b01100;
    localparam logic [4:0] OpLui    = 5'b01101;
    localparam logic [4:0] OpBranch = 5'b11000;
    localparam logic [4:0] OpJalr   = 5'b11001;
    localparam logic [4:0] OpJal    = 5'b11011;

    // branch funct3
    localparam logic [2:0] F3Beq  = 3'b000;
    localparam logic [2:0] F3Bne  = 3'b001;
    localparam logic [2:0] F3Blt  = 3'b100;
    localparam logic [2:0] F3Bge  = 3'b101;
    localparam logic [2:0] F3Bltu = 3'b110;
    localparam logic [2:0] F3Bgeu = 3'b111;

    //////////////////////////////
    // select encodings
    //////////////////////////////
    typedef enum logic [2:0] {
        ImmI      = 3'd0,
        ImmIshift = 3'd1,   // shamt form
        ImmS      = 3'd2,
        ImmB      = 3'd3,
        ImmU      = 3'd4,
        ImmJ      = 3'd5
    } ImmFmt_t;

    typedef enum logic [3:0] {
        AluAdd   = 4'd0,
        AluSub   = 4'd1,
        AluAnd   = 4'd2,
        AluOr    = 4'd3,
        AluXor   = 4'd4,
        AluSll   = 4'd5,
        AluSrl   = 4'd6,
        AluSra   = 4'd7,
        AluSltu  = 4'd8,
        AluSlt   = 4'd9,
        AluPassB = 4'd11    // lui, b operand straight through
    } AluOp_t;

    typedef enum logic [1:0] {
        FwdNone = 2'd0,
        FwdWb   = 2'd1,
        FwdMem  = 2'd2
    } FwdSel_t;

    typedef enum logic [1:0] {
        WbDmem    = 2'd0,
        WbAlu     = 2'd1,
        WbPcPlus4 = 2'd3
    } WbSel_t;

    //////////////////////////////
    // stage bundles, zero = bubble
    //////////////////////////////
    typedef struct packed {
        AluOp_t     aluOp;
        logic       aSelPc;         // a operand from pc
        logic       bSelImm;        // b operand from imm
        logic       branchUnsigned;
        logic       isBranch;
        logic       isJump;
        logic       isStore;
        logic       regWEn;
        WbSel_t     wbSel;
        logic       usesRs1;
        logic       usesRs2;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        logic [2:0] funct3;
    } exBundle_t;

    typedef struct packed {
        logic       isBranch;
        logic       isJump;
        logic       isStore;
        logic       regWEn;
        WbSel_t     wbSel;
        logic [4:0] rd;
        logic [2:0] funct3;
        logic       brEq;   // comparator, sampled in ex
        logic       brLt;
    } memBundle_t;

    typedef struct packed {
        logic       regWEn;
        WbSel_t     wbSel;
        logic [4:0] rd;
    } wbBundle_t;

endpackage

// ==== rtl/forwardUnit.sv ====
`timescale 1ns/1ps

module forwardUnit (
    input  logic               [4:0] memRd,
    input  logic               [4:0] wbRd,
    input  logic                     memRegWEn,
    input  logic                     wbRegWEn,
    input  ctrlPkg::exBundle_t       exCtrl,
    output ctrlPkg::FwdSel_t         fwdA,
    output ctrlPkg::FwdSel_t         fwdB,
    output ctrlPkg::FwdSel_t         fwdStore,
    output ctrlPkg::FwdSel_t         fwdBranchA,
    output ctrlPkg::FwdSel_t         fwdBranchB
);
    import ctrlPkg::*;

    logic [4:0] rs1Use;   // zero when not read
    logic [4:0] rs2Use;
    FwdSel_t    sel1;
    FwdSel_t    sel2;

    // nearest older writer wins, x0 never forwards
    function automatic FwdSel_t pickSrc(
        input logic [4:0] rs,
        input logic       mWEn,
        input logic [4:0] mRd,
        input logic       wWEn,
        input logic [4:0] wRd
    );
        FwdSel_t sel;
        sel = FwdNone;
        if (rs != 5'd0 && mWEn && mRd == rs)
            sel = FwdMem;
        else if (rs != 5'd0 && wWEn && wRd == rs)
            sel = FwdWb;
        return sel;
    endfunction

    assign rs1Use = exCtrl.usesRs1 ? exCtrl.rs1 : 5'd0;
    assign rs2Use = exCtrl.usesRs2 ? exCtrl.rs2 : 5'd0;

    assign sel1 = pickSrc(rs1Use, memRegWEn, memRd, wbRegWEn, wbRd);
    assign sel2 = pickSrc(rs2Use, memRegWEn, memRd, wbRegWEn, wbRd);

    //////////////////////////////
    // route to the consumer
    //////////////////////////////
    always_comb begin
        fwdA       = FwdNone;
        fwdB       = FwdNone;
        fwdStore   = FwdNone;
        fwdBranchA = FwdNone;
        fwdBranchB = FwdNone;
        if (exCtrl.isBranch) begin
            // comparator only, alu computes pc + imm
            fwdBranchA = sel1;
            fwdBranchB = sel2;
        end else begin
            fwdA = sel1;
            if (exCtrl.isStore)
                fwdStore = sel2;    // rs2 is store data
            else
                fwdB = sel2;
        end
    end

endmodule

// ==== rtl/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
    input  logic [31:0]        instr,
    output ctrlPkg::exBundle_t exCtrl,
    output ctrlPkg::ImmFmt_t   immFmt,
    output logic               jumpEarly,
    output logic               branchEarly,
    output logic               idLoad
);
    import ctrlPkg::*;

    logic [4:0] opcode;
    logic [2:0] f3;
    logic       bit30;      // sub / sra select
    logic       live;       // decode is not a bubble
    AluOp_t     arithOp;    // shared by r and i arithmetic

    assign opcode = instr[6:2];
    assign f3     = instr[14:12];
    assign bit30  = instr[30];

    // early flags for the front end
    assign jumpEarly   = (opcode == OpJal);
    assign branchEarly = (opcode == OpBranch);
    assign idLoad      = (opcode == OpLoad);   // for load-use stall

    always_comb begin
        case (f3)
            3'b000:  arithOp = (bit30 && opcode == OpReg) ? AluSub : AluAdd; // no subi
            3'b001:  arithOp = AluSll;
            3'b010:  arithOp = AluSlt;
            3'b011:  arithOp = AluSltu;
            3'b100:  arithOp = AluXor;
            3'b101:  arithOp = bit30 ? AluSra : AluSrl;
            3'b110:  arithOp = AluOr;
            default: arithOp = AluAnd;
        endcase
    end

    //////////////////////////////
    // main decode table
    //////////////////////////////
    always_comb begin
        exCtrl = '0;
        immFmt = ImmI;
        case (opcode)
            OpReg: begin
                exCtrl.aluOp   = arithOp;
                exCtrl.regWEn  = 1'b1;
                exCtrl.wbSel   = WbAlu;
                exCtrl.usesRs1 = 1'b1;
                exCtrl.usesRs2 = 1'b1;
            end
            OpImm: begin
                exCtrl.aluOp   = arithOp;
                exCtrl.bSelImm = 1'b1;
                exCtrl.regWEn  = 1'b1;
                exCtrl.wbSel   = WbAlu;
                exCtrl.usesRs1 = 1'b1;
                if (f3 == 3'b001 || f3 == 3'b101)
                    immFmt = ImmIshift;     // slli srli srai
            end
            OpLoad: begin
                exCtrl.bSelImm = 1'b1;      // address = rs1 + imm
                exCtrl.regWEn  = 1'b1;
                exCtrl.wbSel   = WbDmem;
                exCtrl.usesRs1 = 1'b1;
            end
            OpStore: begin
                exCtrl.bSelImm = 1'b1;
                exCtrl.isStore = 1'b1;
                exCtrl.usesRs1 = 1'b1;
                exCtrl.usesRs2 = 1'b1;      // store data
                immFmt         = ImmS;
            end
            OpBranch: begin
                if (f3[2:1] != 2'b01) begin // 010 and 011 unused
                    exCtrl.isBranch       = 1'b1;
                    exCtrl.aSelPc         = 1'b1;   // target = pc + imm
                    exCtrl.bSelImm        = 1'b1;
                    exCtrl.branchUnsigned = f3[1];  // bltu bgeu
                    exCtrl.usesRs1        = 1'b1;
                    exCtrl.usesRs2        = 1'b1;
                end
                immFmt = ImmB;
            end
            OpJal: begin
                exCtrl.aSelPc  = 1'b1;
                exCtrl.bSelImm = 1'b1;
                exCtrl.isJump  = 1'b1;
                exCtrl.regWEn  = 1'b1;
                exCtrl.wbSel   = WbPcPlus4; // link
                immFmt         = ImmJ;
            end
            OpJalr: begin
                if (f3 == 3'b000) begin
                    exCtrl.bSelImm = 1'b1;
                    exCtrl.isJump  = 1'b1;
                    exCtrl.regWEn  = 1'b1;
                    exCtrl.wbSel   = WbPcPlus4;
                    exCtrl.usesRs1 = 1'b1;
                end
            end
            OpAuipc: begin
                exCtrl.aSelPc  = 1'b1;
                exCtrl.bSelImm = 1'b1;
                exCtrl.regWEn  = 1'b1;
                exCtrl.wbSel   = WbAlu;
                immFmt         = ImmU;
            end
            OpLui: begin
                exCtrl.aluOp   = AluPassB;
                exCtrl.bSelImm = 1'b1;
                exCtrl.regWEn  = 1'b1;
                exCtrl.wbSel   = WbAlu;
                immFmt         = ImmU;
            end
            default: ;  // unknown opcode, bubble
        endcase

        // register numbers only ride with a real instruction
        live = exCtrl.regWEn | exCtrl.isStore | exCtrl.isBranch | exCtrl.isJump;
        if (live) begin
            exCtrl.rs1    = instr[19:15];
            exCtrl.rs2    = instr[24:20];
            exCtrl.funct3 = f3;
            exCtrl.rd     = exCtrl.regWEn ? instr[11:7] : 5'd0;
        end
    end

endmodule

// ==== rtl/pipeCtrl.sv ====
`timescale 1ns/1ps

module pipeCtrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic            [31:0] instr,        // id
    input  logic                   brEq,         // ex
    input  logic                   brLt,
    input  logic                   jumpTaken,    // mem
    input  logic             [1:0] flushIn,
    // id
    output ctrlPkg::ImmFmt_t       immFmt,
    output logic                   jumpEarly,
    output logic                   branchEarly,
    output logic                   idLoad,
    // ex
    output logic                   branchUnsigned,
    output logic                   aluASel,
    output logic                   aluBSel,
    output ctrlPkg::AluOp_t        aluOp,
    output ctrlPkg::FwdSel_t       fwdA,
    output ctrlPkg::FwdSel_t       fwdB,
    output ctrlPkg::FwdSel_t       fwdStore,
    output ctrlPkg::FwdSel_t       fwdBranchA,
    output ctrlPkg::FwdSel_t       fwdBranchB,
    // mem
    output logic                   dmemWrite,
    output logic             [2:0] funct3,
    output logic                   pcSel,
    output logic                   branchResolved,
    output logic                   actualTaken,
    output logic                   mispredict,
    output logic             [1:0] flushOut,
    // wb
    output logic                   regWEn,
    output ctrlPkg::WbSel_t        wbSel
);
    import ctrlPkg::*;

    exBundle_t  exD;
    exBundle_t  exQ;
    memBundle_t memD;
    memBundle_t memQ;
    wbBundle_t  wbD;
    wbBundle_t  wbQ;

    //////////////////////////////
    // id
    //////////////////////////////
    instrDecoder decoder_i (
        .instr       (instr),
        .exCtrl      (exD),
        .immFmt      (immFmt),
        .jumpEarly   (jumpEarly),
        .branchEarly (branchEarly),
        .idLoad      (idLoad)
    );

    stageReg #(.payload_t(exBundle_t)) exStage (
        .clk   (clk),
        .rst   (rst),
        .flush (flushOut[0]),
        .d     (exD),
        .q     (exQ)
    );

    //////////////////////////////
    // ex
    //////////////////////////////
    assign branchUnsigned = exQ.branchUnsigned;
    assign aluASel        = exQ.aSelPc;
    assign aluBSel        = exQ.bSelImm;
    assign aluOp          = exQ.aluOp;

    forwardUnit fwd_i (
        .memRd      (memQ.rd),
        .wbRd       (wbQ.rd),
        .memRegWEn  (memQ.regWEn),
        .wbRegWEn   (wbQ.regWEn),
        .exCtrl     (exQ),
        .fwdA       (fwdA),
        .fwdB       (fwdB),
        .fwdStore   (fwdStore),
        .fwdBranchA (fwdBranchA),
        .fwdBranchB (fwdBranchB)
    );

    // drop alu-only fields, pick up the compare result
    always_comb begin
        memD.isBranch = exQ.isBranch;
        memD.isJump   = exQ.isJump;
        memD.isStore  = exQ.isStore;
        memD.regWEn   = exQ.regWEn;
        memD.wbSel    = exQ.wbSel;
        memD.rd       = exQ.rd;
        memD.funct3   = exQ.funct3;
        memD.brEq     = brEq;
        memD.brLt     = brLt;
    end

    stageReg #(.payload_t(memBundle_t)) memStage (
        .clk   (clk),
        .rst   (rst),
        .flush (flushOut[1]),
        .d     (memD),
        .q     (memQ)
    );

    //////////////////////////////
    // mem
    //////////////////////////////
    assign dmemWrite = memQ.isStore;
    assign funct3    = memQ.funct3;   // load/store width too

    branchResolve resolve_i (
        .memCtrl        (memQ),
        .jumpTaken      (jumpTaken),
        .flushIn        (flushIn),
        .pcSel          (pcSel),
        .branchResolved (branchResolved),
        .actualTaken    (actualTaken),
        .mispredict     (mispredict),
        .flushOut       (flushOut)
    );

    always_comb begin
        wbD.regWEn = memQ.regWEn;
        wbD.wbSel  = memQ.wbSel;
        wbD.rd     = memQ.rd;
    end

    stageReg #(.payload_t(wbBundle_t)) wbStage (
        .clk   (clk),
        .rst   (rst),
        .flush (1'b0),      // mem instr always retires
        .d     (wbD),
        .q     (wbQ)
    );

    // wb
    assign regWEn = wbQ.regWEn;
    assign wbSel  = wbQ.wbSel;

endmodule

// ==== rtl/stageReg.sv ====
`timescale 1ns/1ps

module stageReg #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,   // turn this entry into a bubble
    input  payload_t d,
    output payload_t q
);

    //////////////////////////////
    // one pipeline stage
    //////////////////////////////
    // all-zero payload reads as a bubble in every bundle
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q <= '0;
        end else begin
            q <= d;     // advance every cycle, no stall
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module pipeCtrlTb -f files.f -o pipeCtrlSim
./obj_dir/pipeCtrlSim > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
grep -q "Result: PASSED" sim.log

// ==== testbench/ctrlPatterns.txt ====
// test_instr_{brEq brLt jumpTaken flushIn}_{immFmt early exSel aluOp}_{fwdA fwdB fwdStore fwdBrA fwdBrB}
// _{dmemWrite funct3 pcSel/resolved/taken/mispredict flushOut}_{regWEn wbSel}, one row per cycle
// reset
1_0000007f_0000_0000_00000_0000_00
1_0000007f_0000_0000_00000_0000_00
// decode: add lw sw lui srai auipc sltu
2_002081b3_0000_0000_00000_0000_00
2_00822283_0000_0100_00000_0000_00
2_0063a223_0000_2010_00000_0000_00
2_12345437_0000_4010_00000_0200_11
2_40355493_0000_101b_00000_1200_10
2_00001597_0000_4017_00000_0500_00
2_00e6b633_0000_0030_00000_0500_11
2_0000007f_0000_0008_00000_0100_11
2_0000007f_0000_0000_00000_0300_11
2_0000007f_0000_0000_00000_0000_11
// forwarding: mem, wb, store, branch, unused source, x0
3_002082b3_0000_0000_00000_0000_00
3_00528333_0000_0000_00000_0000_00
3_00532023_0000_2000_22000_0000_00
3_00030463_0000_3210_20100_0000_11
3_00100293_0000_0030_00010_1200_11
3_00028537_0000_4010_00000_0040_00
3_00050013_0000_001b_00000_0000_00
3_000005b3_0000_0010_20000_0000_11
3_0000007f_0000_0000_00000_0000_11
3_0000007f_0000_0000_00000_0000_11
3_0000007f_0000_0000_00000_0000_11
// branches on each funct3, jal unpredicted and predicted
4_00209463_0000_3200_00000_0000_00
4_0020c463_1000_3230_00000_0000_00
4_0020f463_0000_3230_00000_0140_00
4_00208463_0100_3270_00000_0440_00
4_0000007f_1000_0030_00000_0740_00
4_0000007f_0000_0000_00000_00e3_00
4_0020d463_0000_3200_00000_0000_00
4_0000007f_0000_0030_00000_0000_00
4_0000007f_0000_0000_00000_05e3_00
4_0020e463_0000_3200_00000_0000_00
4_010000ef_0100_5470_00000_0000_00
4_0000007f_0010_0030_00000_0660_00
4_0000007f_0000_0000_00000_0083_00
4_010000ef_0000_5400_00000_0000_13
4_0000007f_0000_0030_00000_0000_00
4_0000007f_0010_0000_00000_0000_00
4_0000007f_0000_0000_00000_0000_13
// mispredict flush, then external flushIn bits
5_0020c463_0000_3200_00000_0000_00
5_002081b3_0000_0030_00000_0000_00
5_12345437_0010_4000_00000_04d3_00
5_00822283_0001_0100_00000_0001_00
5_0063a223_0000_2000_00000_0000_00
5_00001597_0002_4010_00000_0002_00
5_0000007f_0000_0030_00000_0000_00
5_0000007f_0000_0000_00000_0100_00
5_0000007f_0000_0000_00000_0000_11

// ==== testbench/pipeCtrlTb.sv ====
`timescale 1ns/1ps

module pipeCtrlTb;
    import ctrlPkg::*;

    localparam int NumRows    = 49;
    localparam int CycleLimit = NumRows + 20;  // plus reset and slack

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic        brEq;
    logic        brLt;
    logic        jumpTaken;
    logic [1:0]  flushIn;

    ImmFmt_t     immFmt;
    logic        jumpEarly;
    logic        branchEarly;
    logic        idLoad;
    logic        branchUnsigned;
    logic        aluASel;
    logic        aluBSel;
    AluOp_t      aluOp;
    FwdSel_t     fwdA;
    FwdSel_t     fwdB;
    FwdSel_t     fwdStore;
    FwdSel_t     fwdBranchA;
    FwdSel_t     fwdBranchB;
    logic        dmemWrite;
    logic [2:0]  funct3;
    logic        pcSel;
    logic        branchResolved;
    logic        actualTaken;
    logic        mispredict;
    logic [1:0]  flushOut;
    logic        regWEn;
    WbSel_t      wbSel;

    logic [111:0] patterns [0:NumRows-1];   // 28 hex digits per row
    int curRow     = 0;
    int errors     = 0;
    int testErrors = 0;
    int testRows   = 0;
    int testCount  = 0;
    int checks     = 0;
    int cycles     = 0;

    pipeCtrl pipeCtrl_i (.*);

    always #10 clk = ~clk;

    // runaway guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", CycleLimit);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic string testName(input logic [3:0] id);
        case (id)
            4'd1:    return "reset";
            4'd2:    return "decode across stages";
            4'd3:    return "forwarding";
            4'd4:    return "branches and jumps";
            4'd5:    return "mispredict and flush";
            default: return "unknown";
        endcase
    endfunction

    // one hex digit of the expected part
    task automatic checkField(input string name, input logic [3:0] got,
                              input logic [3:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error: %s row %0d expected %h got %h", name, curRow, exp, got);
            errors++;
            testErrors++;
        end
    endtask

    //////////////////////////////
    // compare all outputs
    //////////////////////////////
    task automatic checkRow(input logic [111:0] p);
        checkField("immFmt", {1'b0, immFmt}, p[59:56]);
        checkField("jumpEarly/branchEarly/idLoad",
                   {1'b0, jumpEarly, branchEarly, idLoad}, p[55:52]);
        checkField("branchUnsigned/aluASel/aluBSel",
                   {1'b0, branchUnsigned, aluASel, aluBSel}, p[51:48]);
        checkField("aluOp", aluOp, p[47:44]);
        checkField("fwdA", {2'b0, fwdA}, p[43:40]);
        checkField("fwdB", {2'b0, fwdB}, p[39:36]);
        checkField("fwdStore", {2'b0, fwdStore}, p[35:32]);
        checkField("fwdBranchA", {2'b0, fwdBranchA}, p[31:28]);
        checkField("fwdBranchB", {2'b0, fwdBranchB}, p[27:24]);
        checkField("dmemWrite", {3'b0, dmemWrite}, p[23:20]);
        checkField("funct3", {1'b0, funct3}, p[19:16]);
        checkField("pcSel/branchResolved/actualTaken/mispredict",
                   {pcSel, branchResolved, actualTaken, mispredict}, p[15:12]);
        checkField("flushOut", {2'b0, flushOut}, p[11:8]);
        checkField("regWEn", {3'b0, regWEn}, p[7:4]);
        checkField("wbSel", {2'b0, wbSel}, p[3:0]);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        instr     = '0;
        brEq      = 1'b0;
        brLt      = 1'b0;
        jumpTaken = 1'b0;
        flushIn   = 2'b00;
        $readmemh("testbench/ctrlPatterns.txt", patterns);
        if ($isunknown(patterns[NumRows-1])) begin
            $display("pattern file missing or shorter than %0d rows", NumRows);
            errors++;
        end

        repeat (3) @(posedge clk);  // reset held for 3 edges
        for (int row = 0; row < NumRows; row++) begin
            rst       <= 1'b0;
            instr     <= patterns[row][107:76];
            brEq      <= patterns[row][72];
            brLt      <= patterns[row][68];
            jumpTaken <= patterns[row][64];
            flushIn   <= patterns[row][61:60];
            @(negedge clk);     // outputs settled mid cycle
            curRow = row;
            checkRow(patterns[row]);
            testRows++;
            // test ends at the last row or where the id changes
            if (row == NumRows - 1 || patterns[row+1][111:108] != patterns[row][111:108]) begin
                $display("test %0d %s: %0d rows, %0d errors", patterns[row][111:108],
                         testName(patterns[row][111:108]), testRows, testErrors);
                testCount++;
                testRows   = 0;
                testErrors = 0;
            end
            @(posedge clk);
        end

        $display("tests %0d, checks %0d, errors %0d", testCount, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
